// File: design/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_params.svh"

module alu
	import dsp_pkg::*;
(
	input  opcode_e      opcode,
	input  word_t        operand_x,
	input  word_t        operand_y,
	output unit_result_t result
);

	// sign bit position.
	localparam int msb = `DSP_DATA_W - 1;

	word_t sum;
	word_t diff;
	logic  sum_ovf;
	logic  diff_ovf;

	// both arithmetic paths are always formed.
	assign sum  = operand_x + operand_y;
	assign diff = operand_x - operand_y;

	// add overflows when both signs agree and the sum sign differs.
	assign sum_ovf = (operand_x[msb] == operand_y[msb]) && (sum[msb] != operand_x[msb]);

	// sub overflows when signs differ and the result sign leaves x.
	assign diff_ovf = (operand_x[msb] != operand_y[msb]) && (diff[msb] != operand_x[msb]);

	always_comb
	begin
		// opcodes owned elsewhere give zero.
		result = '0;
		case (opcode)
			OP_ADD:
			begin
				result.data = sum;
				result.ovf  = sum_ovf;
			end
			OP_SUB:
			begin
				result.data = diff;
				result.ovf  = diff_ovf;
			end
			// logic ops never overflow.
			OP_AND:
			begin
				result.data = operand_x & operand_y;
			end
			OP_OR:
			begin
				result.data = operand_x | operand_y;
			end
			OP_XOR:
			begin
				result.data = operand_x ^ operand_y;
			end
			OP_PASS:
			begin
				result.data = operand_x;
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/compute_block.sv
`timescale 1ns/1ps
`default_nettype none

module compute_block
	import dsp_pkg::*;
(
	input  wire    clk,
	input  wire    arst_n,
	input  wire    instr_valid,
	input  instr_t instr,
	output wb_t    wb,
	output flags_t flags
);

	// operands from the register file.
	word_t        operand_x;
	word_t        operand_y;

	// unit outputs into the crossbar.
	unit_result_t alu_result;
	unit_result_t mul_result;

	// write-back path from the crossbar.
	logic         rf_write_en;
	addr_t        rf_write_addr;
	word_t        rf_write_data;

	regfile u_regfile (
		.clk         (clk),
		.write_en    (rf_write_en),
		.write_addr  (rf_write_addr),
		.write_data  (rf_write_data),
		.read_addr_x (instr.srcx),
		.read_addr_y (instr.srcy),
		.read_data_x (operand_x),
		.read_data_y (operand_y)
	);

	// alu and multiplier see the same operands.
	alu u_alu (
		.opcode    (instr.opcode),
		.operand_x (operand_x),
		.operand_y (operand_y),
		.result    (alu_result)
	);

	multiplier u_multiplier (
		.opcode    (instr.opcode),
		.operand_x (operand_x),
		.operand_y (operand_y),
		.result    (mul_result)
	);

	crossbar u_crossbar (
		.clk           (clk),
		.arst_n        (arst_n),
		.instr_valid   (instr_valid),
		.opcode        (instr.opcode),
		.dst           (instr.dst),
		.load_data     (instr.load_data),
		.alu_result    (alu_result),
		.mul_result    (mul_result),
		.rf_write_en   (rf_write_en),
		.rf_write_addr (rf_write_addr),
		.rf_write_data (rf_write_data),
		.wb            (wb),
		.flags         (flags)
	);

endmodule

`default_nettype wire

// File: design/crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_params.svh"

module crossbar
	import dsp_pkg::*;
(
	input  wire          clk,
	input  wire          arst_n,
	input  wire          instr_valid,
	input  opcode_e      opcode,
	input  addr_t        dst,
	input  word_t        load_data,
	input  unit_result_t alu_result,
	input  unit_result_t mul_result,
	output logic         rf_write_en,
	output addr_t        rf_write_addr,
	output word_t        rf_write_data,
	output wb_t          wb,
	output flags_t       flags
);

	unit_result_t sel;
	logic         sel_valid;

	// opcode class decode.
	// undefined codes and nop select nothing.
	always_comb
	begin
		sel       = '0;
		sel_valid = 1'b1;
		case (opcode)
			OP_LOAD:
			begin
				sel.data = load_data;
			end
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PASS:
			begin
				sel = alu_result;
			end
			OP_MUL_LO, OP_MUL_HI, OP_MUL_FRAC:
			begin
				sel = mul_result;
			end
			default:
			begin
				sel_valid = 1'b0;
			end
		endcase
	end

	// register file write, same cycle as issue.
	assign rf_write_en   = instr_valid && sel_valid;
	assign rf_write_addr = dst;
	assign rf_write_data = sel.data;

	// wb report is reloaded every edge, zero when idle.
	// flags hold their value across idle cycles.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb    <= '0;
			flags <= '0;
		end
		else if (rf_write_en)
		begin
			wb.en      <= 1'b1;
			wb.addr    <= dst;
			wb.data    <= sel.data;
			flags.zero <= (sel.data == '0);
			flags.neg  <= sel.data[`DSP_DATA_W-1];
			flags.ovf  <= sel.ovf;
		end
		else
		begin
			wb <= '0;
		end
	end

endmodule

`default_nettype wire

// File: design/dsp_pkg.sv
`default_nettype none

package dsp_pkg;

	`include "dsp_params.svh"

	// one data word and one register address.
	typedef logic [`DSP_DATA_W-1:0] word_t;
	typedef logic [`DSP_ADDR_W-1:0] addr_t;

	// instruction opcodes, 4 bits wide.
	typedef enum logic [3:0]
	{
		OP_NOP,
		OP_LOAD,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_PASS,
		OP_MUL_LO,
		OP_MUL_HI,
		OP_MUL_FRAC
	} opcode_e;

	// one instruction as issued to the compute block.
	typedef struct packed
	{
		opcode_e opcode;
		addr_t   dst;
		addr_t   srcx;
		addr_t   srcy;
		word_t   load_data;
	} instr_t;

	// output of the alu or the multiplier.
	typedef struct packed
	{
		word_t data;
		logic  ovf;
	} unit_result_t;

	// report of the last register write.
	typedef struct packed
	{
		logic  en;
		addr_t addr;
		word_t data;
	} wb_t;

	// status of the last written value.
	typedef struct packed
	{
		logic zero;
		logic neg;
		logic ovf;
	} flags_t;

endpackage

`default_nettype wire

// File: design/multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_params.svh"

module multiplier
	import dsp_pkg::*;
(
	input  opcode_e      opcode,
	input  word_t        operand_x,
	input  word_t        operand_y,
	output unit_result_t result
);

	// full product width and q15 rounding constant.
	localparam int prod_w = 2 * `DSP_DATA_W;
	localparam int half   = 1 << (`DSP_DATA_W - 2);

	// most negative and most positive words.
	localparam word_t word_min = {1'b1, {(`DSP_DATA_W - 1){1'b0}}};
	localparam word_t word_max = ~word_min;

	logic signed [prod_w-1:0] product;
	logic signed [prod_w-1:0] rounded;
	logic                     lo_ovf;
	logic                     frac_sat;

	// signed 16x16 product, full 32 bits.
	assign product = $signed(operand_x) * $signed(operand_y);

	// round to nearest before dropping the low 15 bits.
	assign rounded = product + half;

	// low word fits only when bits 31..15 are all sign copies.
	assign lo_ovf = product[prod_w-1:`DSP_DATA_W-1] != {(`DSP_DATA_W + 1){product[`DSP_DATA_W-1]}};

	// -1.0 times -1.0 is the only q15 product out of range.
	assign frac_sat = (operand_x == word_min) && (operand_y == word_min);

	always_comb
	begin
		// non-multiply opcodes give zero.
		result = '0;
		case (opcode)
			OP_MUL_LO:
			begin
				result.data = product[`DSP_DATA_W-1:0];
				result.ovf  = lo_ovf;
			end
			// high word always fits.
			OP_MUL_HI:
			begin
				result.data = product[prod_w-1:`DSP_DATA_W];
			end
			OP_MUL_FRAC:
			begin
				result.data = frac_sat ? word_max : rounded[prod_w-2:`DSP_DATA_W-1];
				result.ovf  = frac_sat;
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: design/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_params.svh"

module regfile
	import dsp_pkg::*;
(
	input  wire   clk,
	input  wire   write_en,
	input  addr_t write_addr,
	input  word_t write_data,
	input  addr_t read_addr_x,
	input  addr_t read_addr_y,
	output word_t read_data_x,
	output word_t read_data_y
);

	// 2**addr_w words, contents are undefined until written.
	word_t mem [2**`DSP_ADDR_W];

	// single write port, taken at the rising edge.
	always_ff @(posedge clk)
	begin
		if (write_en)
		begin
			mem[write_addr] <= write_data;
		end
	end

	// two asynchronous read ports.
	// a write is seen by the reads right after its edge.
	always_comb
	begin
		read_data_x = mem[read_addr_x];
		read_data_y = mem[read_addr_y];
	end

endmodule

`default_nettype wire

// File: include/dsp_params.svh
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// width of a data word and of a register address.
`define DSP_DATA_W 16
`define DSP_ADDR_W 4

`endif

// File: run.sh
#!/bin/sh
# build and run the compute block testbench with verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_compute_block -o tb_compute_block
# a failing run exits non-zero, the log decides the result.
./obj_dir/tb_compute_block > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
	echo "FAIL"
	exit 1
fi
echo "PASS"
exit 0

// File: sim.f
+incdir+include
design/dsp_pkg.sv
design/regfile.sv
design/alu.sv
design/multiplier.sv
design/crossbar.sv
design/compute_block.sv
testbench/tb_compute_block.sv

// File: testbench/tb_compute_block.sv
`timescale 1ns/1ps
`default_nettype none

`include "dsp_params.svh"

module tb_compute_block
	import dsp_pkg::*;
();

	localparam int num_regs = 2 ** `DSP_ADDR_W;

	logic   clk = 1'b0;
	logic   arst_n;
	logic   instr_valid;
	instr_t instr;
	wb_t    wb;
	flags_t flags;

	// lfsr state and the software model of the register file.
	logic [31:0]          lfsr_state;
	word_t [num_regs-1:0] model_regs;
	flags_t               model_flags;

	// expected outputs staged to meet the dut one edge later.
	logic   pend_armed = 1'b0;
	wb_t    pend_wb;
	flags_t pend_flags;
	logic   chk_armed = 1'b0;
	wb_t    chk_wb;
	flags_t chk_flags;

	compute_block u_compute_block (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.flags       (flags)
	);

	// 100 ns clock.
	always #50 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	// fibonacci lfsr with taps 32 22 2 1, stepped once per bit.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic word_t rand_word();
		word_t v;
		int    k;
		v = '0;
		for (k = 0; k < `DSP_DATA_W; k++)
			v = {v[`DSP_DATA_W-2:0], lfsr_bit()};
		return v;
	endfunction

	function automatic addr_t rand_addr();
		addr_t v;
		int    k;
		v = '0;
		for (k = 0; k < `DSP_ADDR_W; k++)
			v = {v[`DSP_ADDR_W-2:0], lfsr_bit()};
		return v;
	endfunction

	function automatic instr_t make_instr(input opcode_e op, input addr_t dst,
		input addr_t srcx, input addr_t srcy, input word_t load_data);
		instr_t ins;
		ins.opcode    = op;
		ins.dst       = dst;
		ins.srcx      = srcx;
		ins.srcy      = srcy;
		ins.load_data = load_data;
		return ins;
	endfunction

	function automatic opcode_e pick_alu_op(input word_t k);
		case (k % 6)
			0: return OP_ADD;
			1: return OP_SUB;
			2: return OP_AND;
			3: return OP_OR;
			4: return OP_XOR;
			default: return OP_PASS;
		endcase
	endfunction

	function automatic opcode_e pick_mul_op(input word_t k);
		case (k % 3)
			0: return OP_MUL_LO;
			1: return OP_MUL_HI;
			default: return OP_MUL_FRAC;
		endcase
	endfunction

	// reference model of one issued instruction.
	function automatic void compute_expected(inout word_t [num_regs-1:0] regs,
		input instr_t ins, input logic valid, output wb_t exp_wb, inout flags_t exp_flags);
		word_t              rx;
		word_t              ry;
		logic signed [31:0] x;
		logic signed [31:0] y;
		logic signed [31:0] s;
		logic signed [31:0] p;
		word_t              res;
		logic               ovf;
		logic               writes;
		rx = regs[ins.srcx];
		ry = regs[ins.srcy];
		x = {{16{rx[15]}}, rx};
		y = {{16{ry[15]}}, ry};
		p = x * y;
		s = '0;
		res = '0;
		ovf = 1'b0;
		writes = valid;
		case (ins.opcode)
			OP_LOAD: res = ins.load_data;
			OP_ADD:
			begin
				s = x + y;
				res = s[15:0];
				ovf = (s > 32767) || (s < -32768);
			end
			OP_SUB:
			begin
				s = x - y;
				res = s[15:0];
				ovf = (s > 32767) || (s < -32768);
			end
			OP_AND: res = rx & ry;
			OP_OR: res = rx | ry;
			OP_XOR: res = rx ^ ry;
			OP_PASS: res = rx;
			OP_MUL_LO:
			begin
				res = p[15:0];
				ovf = (p > 32767) || (p < -32768);
			end
			OP_MUL_HI: res = p[31:16];
			OP_MUL_FRAC:
			begin
				// q15 product rounded to nearest.
				// -1.0 squared saturates.
				if (rx == 16'h8000 && ry == 16'h8000)
				begin
					res = 16'h7fff;
					ovf = 1'b1;
				end
				else
				begin
					s = (p + 16384) >>> 15;
					res = s[15:0];
				end
			end
			default: writes = 1'b0;
		endcase
		exp_wb = '0;
		if (writes)
		begin
			regs[ins.dst]  = res;
			exp_wb.en      = 1'b1;
			exp_wb.addr    = ins.dst;
			exp_wb.data    = res;
			exp_flags.zero = (res == '0);
			exp_flags.neg  = res[15];
			exp_flags.ovf  = ovf;
		end
	endfunction

	// drive one instruction at the rising edge and queue its expectation.
	task automatic issue(input logic valid, input instr_t ins);
		wb_t e_wb;
		@(posedge clk);
		compute_expected(model_regs, ins, valid, e_wb, model_flags);
		instr_valid <= valid;
		instr       <= ins;
		pend_wb     <= e_wb;
		pend_flags  <= model_flags;
		pend_armed  <= 1'b1;
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (arst_n !== 1'b1 && n < 16)
		begin
			@(posedge clk);
			n++;
		end
		if (arst_n !== 1'b1)
			fail_run("reset was not released within 16 cycles");
	endtask

	// compares the outputs of the instruction driven two edges earlier.
	always @(posedge clk)
	begin
		if (chk_armed)
		begin
			assert (wb === chk_wb)
			else
				fail_run($sformatf("ERR wb expected 0x%h actual 0x%h", chk_wb, wb));
			assert (flags === chk_flags)
			else
				fail_run($sformatf("ERR flags expected 0x%h actual 0x%h", chk_flags, flags));
		end
		chk_armed <= pend_armed;
		chk_wb    <= pend_wb;
		chk_flags <= pend_flags;
	end

	initial
	begin
		int      i;
		word_t   w;
		addr_t   d;
		addr_t   prev;
		opcode_e op;
		instr_t  ins;
		lfsr_state  = 32'h8715_d7d0;
		arst_n      = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		model_regs  = '0;
		model_flags = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		wait_reset_release();
		assert (wb === '0)
		else
			fail_run($sformatf("ERR wb expected 0x%h actual 0x%h", 21'h0, wb));
		assert (flags === '0)
		else
			fail_run($sformatf("ERR flags expected 0x%h actual 0x%h", 3'h0, flags));

		// every register gets random load data.
		for (i = 0; i < num_regs; i++)
			issue(1'b1, make_instr(OP_LOAD, i[3:0], 4'h0, 4'h0, rand_word()));

		// random alu traffic.
		for (i = 0; i < 200; i++)
			issue(1'b1, make_instr(pick_alu_op(rand_word()), rand_addr(), rand_addr(),
				rand_addr(), rand_word()));

		// random multiplies followed by the corner operands.
		for (i = 0; i < 40; i++)
			issue(1'b1, make_instr(pick_mul_op(rand_word()), rand_addr(), rand_addr(),
				rand_addr(), rand_word()));
		issue(1'b1, make_instr(OP_LOAD, 4'h1, 4'h0, 4'h0, 16'h8000));
		issue(1'b1, make_instr(OP_LOAD, 4'h2, 4'h0, 4'h0, 16'h7fff));
		issue(1'b1, make_instr(OP_LOAD, 4'h3, 4'h0, 4'h0, 16'h0000));
		for (i = 0; i < 3; i++)
		begin
			op = pick_mul_op(i[15:0]);
			issue(1'b1, make_instr(op, 4'h5, 4'h1, 4'h1, '0));
			issue(1'b1, make_instr(op, 4'h5, 4'h2, 4'h2, '0));
			issue(1'b1, make_instr(op, 4'h5, 4'h3, 4'h1, '0));
			issue(1'b1, make_instr(op, 4'h5, 4'h1, 4'h2, '0));
		end

		// each instruction reads the destination of the one before.
		prev = rand_addr();
		for (i = 0; i < 40; i++)
		begin
			d = rand_addr();
			w = rand_word();
			op = w[15] ? pick_alu_op(w) : pick_mul_op(w);
			issue(1'b1, make_instr(op, d, prev, rand_addr(), rand_word()));
			prev = d;
		end

		// idle cycles with random fields and either valid low or a valid nop.
		for (i = 0; i < 30; i++)
		begin
			w = rand_word();
			ins = make_instr(opcode_e'(w[3:0]), rand_addr(), rand_addr(), rand_addr(),
				rand_word());
			if (w[4])
				ins.opcode = OP_NOP;
			issue(w[4], ins);
		end

		// pass sweep shows every register kept its value.
		for (i = 0; i < num_regs; i++)
			issue(1'b1, make_instr(OP_PASS, i[3:0], i[3:0], rand_addr(), rand_word()));
		issue(1'b0, '0);
		repeat (3) @(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
